// ==== hw/sd_fifo_head_s.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

// Write side of the FIFO, runs in the consumer clock
module sd_fifo_head_s
  #(
    parameter int depth = `SD_FIFO_DEPTH,
    parameter bit async = `SD_FIFO_ASYNC,
    localparam int asz  = $clog2(depth)
    )
  (
   input  logic         clk,
   input  logic         reset,
   input  logic         c_srdy,
   output logic         c_drdy,

   output logic [asz:0]   wrptr_head,
   output logic [asz-1:0] wr_addr,
   output logic           wr_en,
   input  logic [asz:0]   rdptr_tail
   );

  // Pointer carries one wrap bit above the address
  localparam int ptr_w = asz + 1;

  logic [asz:0]      wrptr;
  logic [asz:0]      rdptr;
  logic              full;
  sd_fifo_pkg::ptr_t rdptr_wide;
  sd_fifo_pkg::ptr_t wrptr_grey;

  // --------------------------------------------------
  // Read pointer from the tail side
  // --------------------------------------------------

  // Decode the returning pointer only when it crossed as grey
  assign rdptr_wide = sd_fifo_pkg::grey2bin(sd_fifo_pkg::ptr_t'(rdptr_tail), ptr_w);
  assign rdptr      = async ? rdptr_wide[asz:0] : rdptr_tail;

  // --------------------------------------------------
  // Full detect and write strobe
  // --------------------------------------------------

  // Same slot, opposite lap means every entry is in use
  assign full = (wrptr[asz-1:0] == rdptr[asz-1:0]) && (wrptr[asz] != rdptr[asz]);

  assign c_drdy  = !full;
  assign wr_en   = c_srdy && !full;
  assign wr_addr = wrptr[asz-1:0];

  // Advance on the same edge that writes the memory
  always_ff @(posedge clk)
  begin
    if (reset)
      wrptr <= '0;
    else if (wr_en)
      wrptr <= wrptr + 1'b1;
  end

  // Export the pointer in the coding the synchronizer expects
  assign wrptr_grey = sd_fifo_pkg::bin2grey(sd_fifo_pkg::ptr_t'(wrptr), ptr_w);
  assign wrptr_head = async ? wrptr_grey[asz:0] : wrptr;

endmodule

`default_nettype wire

// ==== hw/sd_fifo_mem.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

// Two-port item storage, write in consumer clock, read in producer clock
module sd_fifo_mem
  #(
    parameter int depth = `SD_FIFO_DEPTH,
    localparam int asz  = $clog2(depth)
    )
  (
   input  logic                    wr_clk,
   input  logic                    wr_en,
   input  logic [asz-1:0]          wr_addr,
   input  sd_fifo_pkg::fifo_item_t wr_data,

   input  logic                    rd_clk,
   input  logic                    rd_en,
   input  logic [asz-1:0]          rd_addr,
   output sd_fifo_pkg::fifo_item_t rd_data
   );

  // Storage array
  sd_fifo_pkg::fifo_item_t mem [depth];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  always_ff @(posedge wr_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Data shows one cycle after rd_en and holds until the next read
  always_ff @(posedge rd_clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hw/sd_fifo_pkg.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

package sd_fifo_pkg;

  // --------------------------------------------------
  // Item and pointer types
  // --------------------------------------------------

  // One FIFO entry, last flag on top of the payload
  typedef struct packed {
    logic                      last;
    logic [`SD_FIFO_WIDTH-1:0] payload;
  } fifo_item_t;

  // Widest pointer the conversion functions handle
  typedef logic [15:0] ptr_t;

  // --------------------------------------------------
  // Pointer coding
  // --------------------------------------------------

  // Binary to grey over the low width bits, upper bits come out zero
  function automatic ptr_t bin2grey(input ptr_t bin_in, input int width);
    ptr_t grey;
    ptr_t shifted;
    grey    = '0;
    shifted = bin_in >> 1;
    for (int b = 0; b < 16; b++)
    begin
      // Top bit of the pointer is copied, the rest xor with the next bit up
      if (b < width - 1)
        grey[b] = bin_in[b] ^ shifted[b];
      else if (b == width - 1)
        grey[b] = bin_in[b];
    end
    return grey;
  endfunction

  // Grey to binary, running xor from the top bit of the pointer down
  function automatic ptr_t grey2bin(input ptr_t grey_in, input int width);
    ptr_t bin;
    logic acc;
    bin = '0;
    acc = 1'b0;
    for (int b = 15; b >= 0; b--)
    begin
      if (b < width)
      begin
        acc    = acc ^ grey_in[b];
        bin[b] = acc;
      end
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== hw/sd_fifo_s.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

// Power-of-two FIFO, consumer side in c_clk, producer side in p_clk
module sd_fifo_s
  #(
    parameter int depth = `SD_FIFO_DEPTH,
    parameter bit async = `SD_FIFO_ASYNC
    )
  (
   input  logic                    c_clk,
   input  logic                    p_clk,
   input  logic                    reset,

   input  logic                    c_srdy,
   output logic                    c_drdy,
   input  sd_fifo_pkg::fifo_item_t c_data,

   output logic                    p_srdy,
   input  logic                    p_drdy,
   output sd_fifo_pkg::fifo_item_t p_data
   );

  localparam int asz = $clog2(depth);

  // --------------------------------------------------
  // Internal nets
  // --------------------------------------------------

  // Memory ports
  logic                    wr_en;
  logic [asz-1:0]          wr_addr;
  logic                    rd_en;
  logic [asz-1:0]          rd_addr;
  sd_fifo_pkg::fifo_item_t rd_data;

  // Pointers as driven, and after crossing
  logic [asz:0] wrptr_head;
  logic [asz:0] wrptr;
  logic [asz:0] rdptr_tail;
  logic [asz:0] rdptr;

  // --------------------------------------------------
  // Consumer clock domain
  // --------------------------------------------------

  sd_fifo_head_s #(.depth(depth), .async(async)) u_head
    (
     .clk        (c_clk),
     .reset      (reset),
     .c_srdy     (c_srdy),
     .c_drdy     (c_drdy),
     .wrptr_head (wrptr_head),
     .wr_addr    (wr_addr),
     .wr_en      (wr_en),
     .rdptr_tail (rdptr)
     );

  // Read pointer coming back from the tail
  sd_ptr_sync #(.width(asz + 1), .async(async)) u_rd_sync
    (
     .clk     (c_clk),
     .reset   (reset),
     .ptr_in  (rdptr_tail),
     .ptr_out (rdptr)
     );

  // Storage spans both domains
  sd_fifo_mem #(.depth(depth)) u_mem
    (
     .wr_clk  (c_clk),
     .wr_en   (wr_en),
     .wr_addr (wr_addr),
     .wr_data (c_data),
     .rd_clk  (p_clk),
     .rd_en   (rd_en),
     .rd_addr (rd_addr),
     .rd_data (rd_data)
     );

  // --------------------------------------------------
  // Producer clock domain
  // --------------------------------------------------

  // Write pointer heading to the tail
  sd_ptr_sync #(.width(asz + 1), .async(async)) u_wr_sync
    (
     .clk     (p_clk),
     .reset   (reset),
     .ptr_in  (wrptr_head),
     .ptr_out (wrptr)
     );

  sd_fifo_tail_s #(.depth(depth), .async(async)) u_tail
    (
     .clk        (p_clk),
     .reset      (reset),
     .p_srdy     (p_srdy),
     .p_drdy     (p_drdy),
     .p_data     (p_data),
     .rdptr_tail (rdptr_tail),
     .wrptr_head (wrptr),
     .rd_addr    (rd_addr),
     .rd_en      (rd_en),
     .rd_data    (rd_data)
     );

endmodule

`default_nettype wire

// ==== hw/sd_fifo_tail_s.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

// Read side of the FIFO, runs in the producer clock
module sd_fifo_tail_s
  #(
    parameter int depth = `SD_FIFO_DEPTH,
    parameter bit async = `SD_FIFO_ASYNC,
    localparam int asz  = $clog2(depth)
    )
  (
   input  logic                   clk,
   input  logic                   reset,
   output logic                   p_srdy,
   input  logic                   p_drdy,
   output sd_fifo_pkg::fifo_item_t p_data,

   output logic [asz:0]           rdptr_tail,
   input  logic [asz:0]           wrptr_head,
   output logic [asz-1:0]         rd_addr,
   output logic                   rd_en,
   input  sd_fifo_pkg::fifo_item_t rd_data
   );

  localparam int ptr_w = asz + 1;

  // rd_issue walks ahead on every memory read
  // rdptr only moves once the item reaches the output register
  logic [asz:0]      rd_issue;
  logic [asz:0]      rdptr;
  logic [asz:0]      wrptr;
  logic              empty;
  logic              rd_pend;
  logic              out_free;
  logic              load;
  sd_fifo_pkg::ptr_t wrptr_wide;
  sd_fifo_pkg::ptr_t rdptr_grey;

  // --------------------------------------------------
  // Write pointer from the head side
  // --------------------------------------------------

  assign wrptr_wide = sd_fifo_pkg::grey2bin(sd_fifo_pkg::ptr_t'(wrptr_head), ptr_w);
  assign wrptr      = async ? wrptr_wide[asz:0] : wrptr_head;

  // Nothing left to fetch once the issue pointer catches up
  assign empty = (wrptr == rd_issue);

  // --------------------------------------------------
  // Read-ahead control
  // --------------------------------------------------

  // Output register is empty or hands its item over this cycle
  assign out_free = !p_srdy || p_drdy;

  // Item returned by the memory moves into the output register
  assign load = rd_pend && out_free;

  // Fetch when no item waits on rd_data, or the waiting one leaves now
  // rd_data holds its value while rd_en stays low
  assign rd_en   = !empty && (!rd_pend || load);
  assign rd_addr = rd_issue[asz-1:0];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_issue <= '0;
      rdptr    <= '0;
      rd_pend  <= 1'b0;
      p_srdy   <= 1'b0;
    end
    else
    begin
      if (rd_en)
        rd_issue <= rd_issue + 1'b1;

      // One read in flight at most
      if (rd_en)
        rd_pend <= 1'b1;
      else if (load)
        rd_pend <= 1'b0;

      // Slot is handed back to the head only when the item is safe in p_data
      if (load)
        rdptr <= rdptr + 1'b1;

      if (load)
        p_srdy <= 1'b1;
      else if (p_drdy)
        p_srdy <= 1'b0;
    end
  end

  // Output payload register
  always_ff @(posedge clk)
  begin
    if (load)
      p_data <= rd_data;
  end

  // --------------------------------------------------
  // Pointer back to the head
  // --------------------------------------------------

  // rdptr steps by one, so the grey value flips a single bit per update
  assign rdptr_grey = sd_fifo_pkg::bin2grey(sd_fifo_pkg::ptr_t'(rdptr), ptr_w);
  assign rdptr_tail = async ? rdptr_grey[asz:0] : rdptr;

endmodule

`default_nettype wire

// ==== hw/sd_ptr_sync.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

// Carries a pointer into the clock domain of clk
module sd_ptr_sync
  #(
    parameter int width = 5,
    parameter bit async = `SD_FIFO_ASYNC
    )
  (
   input  logic             clk,
   input  logic             reset,
   input  logic [width-1:0] ptr_in,
   output logic [width-1:0] ptr_out
   );

  if (async)
  begin : g_sync
    // First stage may go metastable, second stage is the one consumers see
    logic [width-1:0] meta;
    logic [width-1:0] stable;

    // Grey input changes one bit at a time, so stable is always old or new
    always_ff @(posedge clk)
    begin
      if (reset)
      begin
        meta   <= '0;
        stable <= '0;
      end
      else
      begin
        meta   <= ptr_in;
        stable <= meta;
      end
    end

    assign ptr_out = stable;
  end
  else
  begin : g_bypass
    // Single clock build, binary pointer with no added latency
    assign ptr_out = ptr_in;
  end

endmodule

`default_nettype wire

// ==== include/sd_fifo_config.svh ====
`ifndef SD_FIFO_CONFIG_SVH
`define SD_FIFO_CONFIG_SVH

// --------------------------------------------------
// FIFO build defaults
// --------------------------------------------------

// Number of entries in the memory
// Head and tail pointer math relies on a power of two
`define SD_FIFO_DEPTH 16

// Payload bits per item, excluding the last flag
`define SD_FIFO_WIDTH 16

// Pointer crossing mode
// 1 sends grey pointers through two flops, 0 passes binary straight through
`define SD_FIFO_ASYNC 1

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FIFO testbench with Verilator, from the project root
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_sd_fifo_s -f tb.f -o tb_sd_fifo_s > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sd_fifo_s > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
# The log decides the result
grep -q "^Testbench passed$" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

// ==== tb.f ====
+incdir+include
hw/sd_fifo_pkg.sv
hw/sd_ptr_sync.sv
hw/sd_fifo_mem.sv
hw/sd_fifo_head_s.sv
hw/sd_fifo_tail_s.sv
hw/sd_fifo_s.sv
testbench/tb_sd_fifo_s.sv

// ==== testbench/tb_sd_fifo_s.sv ====
`default_nettype none

`include "sd_fifo_config.svh"

module tb_sd_fifo_s;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth   = `SD_FIFO_DEPTH;
  localparam int nphases = 9;

  // Handshake modes of one table row
  localparam logic [1:0] mode_off  = 2'd0;
  localparam logic [1:0] mode_on   = 2'd1;
  localparam logic [1:0] mode_rand = 2'd2;

  // One row of the stimulus table
  typedef struct packed {
    logic [15:0] len;
    logic [1:0]  c_mode;
    logic [1:0]  p_mode;
  } phase_t;

  logic                    clk;
  logic                    reset;
  logic                    c_srdy;
  logic                    c_drdy;
  sd_fifo_pkg::fifo_item_t c_data;
  logic                    p_srdy;
  logic                    p_drdy;
  sd_fifo_pkg::fifo_item_t p_data;

  phase_t                  phases [nphases];
  // Items accepted by the FIFO and not yet seen at the producer port
  sd_fifo_pkg::fifo_item_t scoreboard [$];
  integer                  seed;
  int                      accepted;
  int                      taken;
  int                      cycles = 0;
  int                      cycle_limit;
  // Transfers seen at the last sample point
  logic                    c_fire;
  logic                    p_fire;

  // Both clock ports share one clock
  // Pointers still cross through the grey path
  sd_fifo_s #(.depth(depth), .async(1'b1)) u_dut
    (
     .c_clk  (clk),
     .p_clk  (clk),
     .reset  (reset),
     .c_srdy (c_srdy),
     .c_drdy (c_drdy),
     .c_data (c_data),
     .p_srdy (p_srdy),
     .p_drdy (p_drdy),
     .p_data (p_data)
     );

  // --------------------------------------------------
  // Clock and cycle limit
  // --------------------------------------------------

  initial
  begin
    clk = 1'b0;
    forever
      #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
      stop_on_error($sformatf("Timeout: run did not finish within %0d clock cycles",
                              cycle_limit));
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic load_phase_table();
    // Idle after reset with nothing written
    phases[0] = '{len: 16'd10,  c_mode: mode_off,  p_mode: mode_off};
    // Streaming both sides
    phases[1] = '{len: 16'd40,  c_mode: mode_on,   p_mode: mode_on};
    // Fill against a stalled producer
    phases[2] = '{len: 16'd32,  c_mode: mode_on,   p_mode: mode_off};
    // Drain
    phases[3] = '{len: 16'd40,  c_mode: mode_off,  p_mode: mode_on};
    // Random stalls on both sides
    phases[4] = '{len: 16'd300, c_mode: mode_rand, p_mode: mode_rand};
    phases[5] = '{len: 16'd150, c_mode: mode_on,   p_mode: mode_rand};
    phases[6] = '{len: 16'd150, c_mode: mode_rand, p_mode: mode_on};
    // Second fill and a final drain
    phases[7] = '{len: 16'd32,  c_mode: mode_on,   p_mode: mode_off};
    phases[8] = '{len: 16'd40,  c_mode: mode_off,  p_mode: mode_on};
  endtask

  function automatic int table_cycles();
    int sum;
    sum = 0;
    foreach (phases[i])
      sum += int'(phases[i].len);
    return sum;
  endfunction

  // Payload counts up
  // Every eighth item closes a packet
  function automatic sd_fifo_pkg::fifo_item_t make_item(input int n);
    sd_fifo_pkg::fifo_item_t item;
    item.payload = n[`SD_FIFO_WIDTH-1:0];
    item.last    = (n[2:0] == 3'd7);
    return item;
  endfunction

  function automatic logic choose_level(input logic [1:0] mode);
    logic [31:0] rnd;
    if (mode == mode_on)
      return 1'b1;
    if (mode == mode_off)
      return 1'b0;
    rnd = $random(seed);
    return rnd[0];
  endfunction

  // --------------------------------------------------
  // Per cycle drive and sample
  // --------------------------------------------------

  task automatic drive_inputs(input logic [1:0] c_mode, input logic [1:0] p_mode);
    // An offered item stays on the bus until the FIFO takes it
    if (!(c_srdy && !c_fire))
    begin
      c_srdy = choose_level(c_mode);
      c_data = make_item(accepted);
    end
    p_drdy = choose_level(p_mode);
  endtask

  // Runs at the falling edge where DUT outputs are stable
  // Values seen here decide the transfers at the next rising edge
  task automatic sample_outputs();
    sd_fifo_pkg::fifo_item_t expected;
    c_fire = c_srdy && c_drdy;
    p_fire = p_srdy && p_drdy;

    // Nothing written yet
    if (accepted == 0)
    begin
      assert (!p_srdy && c_drdy)
      else stop_on_error($sformatf("Fail at %0d ns: idle FIFO shows p_srdy=%0b c_drdy=%0b",
                                   $time, p_srdy, c_drdy));
    end

    if (p_fire)
    begin
      assert (scoreboard.size() > 0)
      else stop_on_error($sformatf("Fail at %0d ns: item delivered with none outstanding",
                                   $time));
      expected = scoreboard.pop_front();
      assert (p_data == expected)
      else stop_on_error({$sformatf("Fail at %0d ns: item %0d expected last=%0b data=%h, ",
                                    $time, taken, expected.last, expected.payload),
                          $sformatf("got last=%0b data=%h", p_data.last, p_data.payload)});
      taken++;
    end

    if (c_fire)
    begin
      scoreboard.push_back(c_data);
      accepted++;
    end

    // Memory entries plus the output register
    assert (scoreboard.size() <= depth + 1)
    else stop_on_error($sformatf("Fail at %0d ns: %0d items held, limit is %0d",
                                 $time, scoreboard.size(), depth + 1));
  endtask

  task automatic check_phase_end(input phase_t ph);
    if (int'(ph.len) < depth + 10)
      return;
    // Stalled producer leaves the FIFO full
    if (ph.c_mode == mode_on && ph.p_mode == mode_off)
    begin
      assert (!c_drdy && scoreboard.size() == depth + 1)
      else stop_on_error($sformatf("Fail at %0d ns: fill ends with c_drdy=%0b and %0d items",
                                   $time, c_drdy, scoreboard.size()));
    end
    // Without new items everything must be out
    if (ph.c_mode == mode_off && ph.p_mode == mode_on)
    begin
      assert (scoreboard.size() == 0 && !p_srdy)
      else stop_on_error($sformatf("Fail at %0d ns: drain ends with p_srdy=%0b and %0d items",
                                   $time, p_srdy, scoreboard.size()));
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial
  begin
    reset    = 1'b1;
    c_srdy   = 1'b0;
    c_data   = '0;
    p_drdy   = 1'b0;
    c_fire   = 1'b0;
    p_fire   = 1'b0;
    accepted = 0;
    taken    = 0;
    seed     = 32'h543d5f66;
    load_phase_table();
    cycle_limit = 2 * table_cycles() + 100;

    repeat (3)
      @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (phases[i])
    begin
      for (int n = 0; n < int'(phases[i].len); n++)
      begin
        @(posedge clk);
        #1;
        drive_inputs(phases[i].c_mode, phases[i].p_mode);
        @(negedge clk);
        sample_outputs();
      end
      check_phase_end(phases[i]);
      $display("Phase %0d done, %0d accepted, %0d taken", i, accepted, taken);
    end

    // No item lost or duplicated over the whole run
    assert (accepted == taken && scoreboard.size() == 0)
      $display("Testbench passed");
    else stop_on_error($sformatf("Fail at %0d ns: %0d accepted but %0d taken",
                                 $time, accepted, taken));
    $finish;
  end

endmodule

`default_nettype wire
